// ==== verilog/lsu_defs.svh ====
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

`default_nettype none

// datapath widths, fixed by rv32
`define LSU_DATA_W 32
`define LSU_ADDR_W 32
`define LSU_REG_W 5 // x0..x31
`define LSU_STRB_W 4 // one bit per byte lane
`define LSU_OFF_W 2 // byte offset inside a word

// device regions whose byte lanes follow the address offset
`define LSU_SRAM_LO 32'h0f00_0000
`define LSU_SRAM_HI 32'h0fff_ffff

`define LSU_FLASH_LO 32'h3000_0000
`define LSU_FLASH_HI 32'h3fff_ffff

`define LSU_SDRAM_LO 32'ha000_0000
`define LSU_SDRAM_HI 32'hbfff_ffff

// uart16550 register block
`define LSU_UART_LO 32'h1000_0000
`define LSU_UART_HI 32'h1000_0fff

`define LSU_PSRAM_LO 32'h8000_0000
`define LSU_PSRAM_HI 32'h9fff_ffff

`default_nettype wire

`endif

// ==== verilog/lsu_op_pkg.sv ====
`include "lsu_defs.svh"
`default_nettype none

package lsu_op_pkg;

	// load opcodes from the decoder, none means no read
	typedef enum logic [2:0] {
		LD_NONE = 3'd0,
		LD_LB   = 3'd1, // sign extended byte
		LD_LH   = 3'd2, // sign extended half
		LD_LW   = 3'd3,
		LD_LBU  = 3'd4, // zero extended byte
		LD_LHU  = 3'd5  // zero extended half
	} load_op_e;

	// store opcodes, none means no write
	typedef enum logic [1:0] {
		ST_NONE = 2'd0,
		ST_SB   = 2'd1,
		ST_SH   = 2'd2,
		ST_SW   = 2'd3
	} store_op_e;

	// one request from execute
	typedef struct packed {
		logic                    wd; // writeback enable
		logic [`LSU_REG_W-1:0]  wreg; // destination register
		logic [`LSU_ADDR_W-1:0] addr; // alu result, address for memory ops
		load_op_e                load_op;
		store_op_e               store_op;
		logic [`LSU_DATA_W-1:0] wdata; // rs2 value for stores
	} lsu_req_t;

	// result handed to writeback
	typedef struct packed {
		logic                    wd;
		logic [`LSU_REG_W-1:0]  wreg;
		logic [`LSU_DATA_W-1:0] wdata;
	} lsu_wb_t;

endpackage

`default_nettype wire

// ==== verilog/lsu_bus_pkg.sv ====
`include "lsu_defs.svh"
`default_nettype none

package lsu_bus_pkg;

	// axi style size code, log2 of bytes per beat
	typedef enum logic [2:0] {
		SIZE_1 = 3'd0,
		SIZE_2 = 3'd1,
		SIZE_4 = 3'd2
	} bus_size_e;

	// read and write address channels share this payload
	typedef struct packed {
		logic [`LSU_ADDR_W-1:0] addr;
		bus_size_e               size;
	} addr_chan_t;

	// write data channel
	typedef struct packed {
		logic [`LSU_DATA_W-1:0] data;
		logic [`LSU_STRB_W-1:0] strb; // byte enables, lane aligned
	} wdata_chan_t;

	// read data is a plain word on r_data_i, no struct needed

endpackage

`default_nettype wire

// ==== verilog/lsu_ctrl.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"
`default_nettype none

module lsu_ctrl (
	input  wire                   clock,
	input  wire                   rstn,
	// execute side
	input  wire                   exu_valid_i,
	output logic                  lsu_ready_o,
	input  lsu_op_pkg::lsu_req_t  req_i,
	output lsu_op_pkg::lsu_req_t  req_o, // latched copy for the datapath
	// bus strobes
	output logic                  ar_valid_o,
	input  wire                   ar_ready_i,
	output logic                  aw_valid_o,
	input  wire                   aw_ready_i,
	output logic                  w_valid_o,
	input  wire                   w_ready_i,
	input  wire                   r_valid_i,
	output logic                  r_ready_o,
	input  wire                   b_valid_i,
	output logic                  b_ready_o,
	// datapath control
	output logic                  load_capture_o,
	// writeback side
	output logic                  lsu_valid_o,
	input  wire                   wbu_ready_i
);
	import lsu_op_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE = 2'd0, // waiting for execute
		S_ADDR = 2'd1, // address (and write data) offered
		S_DATA = 2'd2, // waiting for read data or write response
		S_DONE = 2'd3  // result held for writeback
	} state_e;

	state_e   state_q;
	state_e   state_d;
	lsu_req_t req_q;
	logic     is_load;
	logic     is_store;
	logic     accept;

	assign accept = exu_valid_i && lsu_ready_o;

	// request held for the whole transaction
	always_ff @(posedge clock) begin
		if (accept) begin
			req_q <= req_i;
		end
	end

	assign req_o = req_q;

	// a load wins if the decoder ever sets both
	assign is_load  = (req_q.load_op != LD_NONE);
	assign is_store = !is_load && (req_q.store_op != ST_NONE);

	always_ff @(posedge clock) begin
		if (!rstn) begin
			state_q <= S_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				if (exu_valid_i) begin
					state_d = S_ADDR;
				end
			end
			S_ADDR: begin
				if (!is_load && !is_store) begin
					state_d = S_DONE; // alu result only, no bus access
				end else if (is_load && ar_ready_i) begin
					state_d = S_DATA;
				end else if (is_store && aw_ready_i && w_ready_i) begin
					state_d = S_DATA; // address and data taken on the same edge
				end
			end
			S_DATA: begin
				if ((is_load && r_valid_i) || (is_store && b_valid_i)) begin
					state_d = S_DONE;
				end
			end
			S_DONE: begin
				if (wbu_ready_i) begin
					state_d = S_IDLE;
				end
			end
			default: state_d = S_IDLE;
		endcase
	end

	// strobes follow the state only
	assign lsu_ready_o = (state_q == S_IDLE);
	assign ar_valid_o  = (state_q == S_ADDR) && is_load;
	assign aw_valid_o  = (state_q == S_ADDR) && is_store;
	assign w_valid_o   = (state_q == S_ADDR) && is_store; // paired with aw
	assign r_ready_o   = (state_q == S_DATA) && is_load; // only after ar accepted
	assign b_ready_o   = (state_q == S_DATA) && is_store;
	assign lsu_valid_o = (state_q == S_DONE);

	// read beat accepted this edge
	assign load_capture_o = r_ready_o && r_valid_i;

endmodule

`default_nettype wire

// ==== verilog/lsu_region_decode.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"
`default_nettype none

module lsu_region_decode (
	input  wire [`LSU_ADDR_W-1:0] addr_i,
	output logic                  lane_shift_o
);

	// inclusive bounds, unsigned compare
	function automatic logic in_range(
		input logic [`LSU_ADDR_W-1:0] addr,
		input logic [`LSU_ADDR_W-1:0] lo,
		input logic [`LSU_ADDR_W-1:0] hi
	);
		in_range = (addr >= lo) && (addr <= hi);
	endfunction

	logic in_sram;
	logic in_flash;
	logic in_sdram;
	logic in_uart;
	logic in_psram;

	assign in_sram  = in_range(addr_i, `LSU_SRAM_LO, `LSU_SRAM_HI);
	assign in_flash = in_range(addr_i, `LSU_FLASH_LO, `LSU_FLASH_HI);
	assign in_sdram = in_range(addr_i, `LSU_SDRAM_LO, `LSU_SDRAM_HI);
	assign in_uart  = in_range(addr_i, `LSU_UART_LO, `LSU_UART_HI);
	assign in_psram = in_range(addr_i, `LSU_PSRAM_LO, `LSU_PSRAM_HI);

	// these devices return the word lane-aligned, so data follows the offset
	assign lane_shift_o = in_sram || in_flash || in_sdram || in_uart || in_psram;

endmodule

`default_nettype wire

// ==== verilog/lsu_store_lane.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"
`default_nettype none

module lsu_store_lane (
	input  lsu_op_pkg::lsu_req_t     req_i,
	input  wire                      lane_shift_i,
	output lsu_bus_pkg::addr_chan_t  aw_o,
	output lsu_bus_pkg::wdata_chan_t w_o
);
	import lsu_op_pkg::*;
	import lsu_bus_pkg::*;

	bus_size_e              size;
	logic [`LSU_STRB_W-1:0] base_strb; // strobe for offset 0
	logic [`LSU_OFF_W-1:0]  off;

	always_comb begin
		case (req_i.store_op)
			ST_SB: begin
				size      = SIZE_1;
				base_strb = 4'b0001;
			end
			ST_SH: begin
				size      = SIZE_2;
				base_strb = 4'b0011;
			end
			ST_SW: begin
				size      = SIZE_4;
				base_strb = 4'b1111;
			end
			default: begin
				size      = SIZE_4; // no store, strobes stay off
				base_strb = '0;
			end
		endcase
	end

	// offset matters only inside device regions
	assign off = lane_shift_i ? req_i.addr[`LSU_OFF_W-1:0] : '0;

	always_comb begin
		aw_o.addr = req_i.addr;
		aw_o.size = size;
		w_o.strb  = base_strb << off; // upper lanes drop out
		w_o.data  = req_i.wdata << {off, 3'b000}; // 8 bits per byte of offset
	end

endmodule

`default_nettype wire

// ==== verilog/lsu_load_extract.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"
`default_nettype none

module lsu_load_extract (
	input  wire                     clock,
	input  wire                     rstn,
	input  lsu_op_pkg::lsu_req_t    req_i,
	input  wire                     lane_shift_i,
	input  wire                     load_capture_i, // read beat taken this edge
	input  wire [`LSU_DATA_W-1:0]   r_data_i,
	output lsu_bus_pkg::addr_chan_t ar_o,
	output logic [`LSU_DATA_W-1:0]  wb_data_o
);
	import lsu_op_pkg::*;
	import lsu_bus_pkg::*;

	bus_size_e              size;
	logic [`LSU_OFF_W-1:0]  off;
	logic [`LSU_DATA_W-1:0] shifted; // addressed byte moved to lane 0
	logic [`LSU_DATA_W-1:0] extended;
	logic [`LSU_DATA_W-1:0] load_q;

	always_comb begin
		case (req_i.load_op)
			LD_LB, LD_LBU: size = SIZE_1;
			LD_LH, LD_LHU: size = SIZE_2;
			default:       size = SIZE_4;
		endcase
	end

	always_comb begin
		ar_o.addr = req_i.addr;
		ar_o.size = size;
	end

	assign off     = lane_shift_i ? req_i.addr[`LSU_OFF_W-1:0] : '0;
	assign shifted = r_data_i >> {off, 3'b000};

	always_comb begin
		case (req_i.load_op)
			LD_LB:   extended = {{(`LSU_DATA_W-8){shifted[7]}}, shifted[7:0]};
			LD_LH:   extended = {{(`LSU_DATA_W-16){shifted[15]}}, shifted[15:0]};
			LD_LBU:  extended = {{(`LSU_DATA_W-8){1'b0}}, shifted[7:0]};
			LD_LHU:  extended = {{(`LSU_DATA_W-16){1'b0}}, shifted[15:0]};
			default: extended = shifted; // lw, word as is
		endcase
	end

	// bus data is gone after the beat, keep the shaped value
	always_ff @(posedge clock) begin
		if (!rstn) begin
			load_q <= '0;
		end else if (load_capture_i) begin
			load_q <= extended;
		end
	end

	// stores and alu ops return the address
	assign wb_data_o = (req_i.load_op != LD_NONE) ? load_q : req_i.addr;

endmodule

`default_nettype wire

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"
`default_nettype none

module lsu_top (
	input  wire                      clock,
	input  wire                      rstn,
	// execute
	input  wire                      exu_valid_i,
	output logic                     lsu_ready_o,
	input  lsu_op_pkg::lsu_req_t     req_i,
	// writeback
	output logic                     lsu_valid_o,
	input  wire                      wbu_ready_i,
	output lsu_op_pkg::lsu_wb_t      wb_o,
	// read address
	output lsu_bus_pkg::addr_chan_t  ar_o,
	output logic                     ar_valid_o,
	input  wire                      ar_ready_i,
	// write address
	output lsu_bus_pkg::addr_chan_t  aw_o,
	output logic                     aw_valid_o,
	input  wire                      aw_ready_i,
	// write data
	output lsu_bus_pkg::wdata_chan_t w_o,
	output logic                     w_valid_o,
	input  wire                      w_ready_i,
	// read data
	input  wire [`LSU_DATA_W-1:0]    r_data_i,
	input  wire                      r_valid_i,
	output logic                     r_ready_o,
	// write response
	input  wire                      b_valid_i,
	output logic                     b_ready_o
);
	import lsu_op_pkg::*;

	lsu_req_t               req_q; // latched request
	logic                   lane_shift;
	logic                   load_capture;
	logic [`LSU_DATA_W-1:0] wb_data;

	lsu_ctrl u_ctrl (
		.clock          (clock),
		.rstn           (rstn),
		.exu_valid_i    (exu_valid_i),
		.lsu_ready_o    (lsu_ready_o),
		.req_i          (req_i),
		.req_o          (req_q),
		.ar_valid_o     (ar_valid_o),
		.ar_ready_i     (ar_ready_i),
		.aw_valid_o     (aw_valid_o),
		.aw_ready_i     (aw_ready_i),
		.w_valid_o      (w_valid_o),
		.w_ready_i      (w_ready_i),
		.r_valid_i      (r_valid_i),
		.r_ready_o      (r_ready_o),
		.b_valid_i      (b_valid_i),
		.b_ready_o      (b_ready_o),
		.load_capture_o (load_capture),
		.lsu_valid_o    (lsu_valid_o),
		.wbu_ready_i    (wbu_ready_i)
	);

	lsu_region_decode u_region (
		.addr_i       (req_q.addr),
		.lane_shift_o (lane_shift)
	);

	lsu_store_lane u_store (
		.req_i        (req_q),
		.lane_shift_i (lane_shift),
		.aw_o         (aw_o),
		.w_o          (w_o)
	);

	lsu_load_extract u_load (
		.clock          (clock),
		.rstn           (rstn),
		.req_i          (req_q),
		.lane_shift_i   (lane_shift),
		.load_capture_i (load_capture),
		.r_data_i       (r_data_i),
		.ar_o           (ar_o),
		.wb_data_o      (wb_data)
	);

	// register index and enable come straight from the latched request
	assign wb_o = '{wd: req_q.wd, wreg: req_q.wreg, wdata: wb_data};

endmodule

`default_nettype wire

// ==== testbench/lsu_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_sva (
	input  wire                  clock,
	input  wire                  rstn,
	input  wire                  lsu_ready_o,
	input  wire                  ar_valid_o,
	input  wire                  ar_ready_i,
	input  wire                  aw_valid_o,
	input  wire                  aw_ready_i,
	input  wire                  w_valid_o,
	input  wire                  w_ready_i,
	input  wire                  r_ready_o,
	input  wire                  b_ready_o,
	input  wire                  lsu_valid_o,
	input  wire                  wbu_ready_i,
	input  lsu_op_pkg::lsu_req_t req_o
);

	// each strobe belongs to one state so at most one is up
	a_onehot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0({lsu_ready_o, ar_valid_o, aw_valid_o, r_ready_o, b_ready_o, lsu_valid_o}))
		else $error("state strobes overlap");

	a_ar_hold: assert property (@(posedge clock) disable iff (!rstn)
		ar_valid_o && !ar_ready_i |=> ar_valid_o)
		else $error("ar_valid_o dropped without ar_ready_i");

	a_aw_hold: assert property (@(posedge clock) disable iff (!rstn)
		aw_valid_o && !(aw_ready_i && w_ready_i) |=> aw_valid_o && w_valid_o)
		else $error("write strobes dropped before both readies");

	// result frozen until writeback takes it
	a_wb_hold: assert property (@(posedge clock) disable iff (!rstn)
		lsu_valid_o && !wbu_ready_i |=> lsu_valid_o && !lsu_ready_o && $stable(req_o))
		else $error("writeback result changed while held");

	a_wb_release: assert property (@(posedge clock) disable iff (!rstn)
		lsu_valid_o && wbu_ready_i |=> lsu_ready_o && !lsu_valid_o)
		else $error("unit not idle after writeback handshake");

endmodule

`default_nettype wire

// ==== testbench/tb_lsu.sv ====
`timescale 1ns/1ps
`include "lsu_defs.svh"
`default_nettype none

module tb_lsu;
	import lsu_op_pkg::*;
	import lsu_bus_pkg::*;

	localparam int wait_limit = 40; // cycles before a wait gives up
	localparam int p_ar = 0;
	localparam int p_aw = 1; // aw and w valid together
	localparam int p_r  = 2;
	localparam int p_b  = 3;
	localparam int p_wb = 4;

	// one stimulus row with its expected bus and writeback values
	typedef struct packed {
		lsu_req_t               req;
		logic [`LSU_DATA_W-1:0] rdata; // word returned on the read channel
		bus_size_e              size;
		logic [`LSU_STRB_W-1:0] strb;
		logic [`LSU_DATA_W-1:0] bus_data; // expected w channel data
		logic [`LSU_DATA_W-1:0] wb_data;
	} row_t;

	logic                   clock;
	logic                   rstn;
	logic                   exu_valid_i;
	logic                   lsu_ready_o;
	lsu_req_t               req_i;
	logic                   lsu_valid_o;
	logic                   wbu_ready_i;
	lsu_wb_t                wb_o;
	addr_chan_t             ar_o;
	logic                   ar_valid_o;
	logic                   ar_ready_i;
	addr_chan_t             aw_o;
	logic                   aw_valid_o;
	logic                   aw_ready_i;
	wdata_chan_t            w_o;
	logic                   w_valid_o;
	logic                   w_ready_i;
	logic [`LSU_DATA_W-1:0] r_data_i;
	logic                   r_valid_i;
	logic                   r_ready_o;
	logic                   b_valid_i;
	logic                   b_ready_o;

	row_t rows[$];
	int   errors;
	int   checks;

	lsu_top uut (
		.clock       (clock),
		.rstn        (rstn),
		.exu_valid_i (exu_valid_i),
		.lsu_ready_o (lsu_ready_o),
		.req_i       (req_i),
		.lsu_valid_o (lsu_valid_o),
		.wbu_ready_i (wbu_ready_i),
		.wb_o        (wb_o),
		.ar_o        (ar_o),
		.ar_valid_o  (ar_valid_o),
		.ar_ready_i  (ar_ready_i),
		.aw_o        (aw_o),
		.aw_valid_o  (aw_valid_o),
		.aw_ready_i  (aw_ready_i),
		.w_o         (w_o),
		.w_valid_o   (w_valid_o),
		.w_ready_i   (w_ready_i),
		.r_data_i    (r_data_i),
		.r_valid_i   (r_valid_i),
		.r_ready_o   (r_ready_o),
		.b_valid_i   (b_valid_i),
		.b_ready_o   (b_ready_o)
	);

	bind lsu_ctrl lsu_sva u_sva (
		.clock       (clock),
		.rstn        (rstn),
		.lsu_ready_o (lsu_ready_o),
		.ar_valid_o  (ar_valid_o),
		.ar_ready_i  (ar_ready_i),
		.aw_valid_o  (aw_valid_o),
		.aw_ready_i  (aw_ready_i),
		.w_valid_o   (w_valid_o),
		.w_ready_i   (w_ready_i),
		.r_ready_o   (r_ready_o),
		.b_ready_o   (b_ready_o),
		.lsu_valid_o (lsu_valid_o),
		.wbu_ready_i (wbu_ready_i),
		.req_o       (req_o)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // 20 ns period
	end

	task automatic check(input logic [63:0] actual, input logic [63:0] expected,
		input string msg);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at time %0t: %s, got %0h, expected %0h",
				$time, msg, actual, expected);
		end
	endtask

	function automatic logic probe(input int sel);
		case (sel)
			p_ar:    probe = ar_valid_o;
			p_aw:    probe = aw_valid_o && w_valid_o;
			p_r:     probe = r_ready_o;
			p_b:     probe = b_ready_o;
			default: probe = lsu_valid_o;
		endcase
	endfunction

	// polls on falling edges, gives up after wait_limit cycles
	task automatic wait_for(input int sel, input string what, output logic ok);
		int n;
		n = 0;
		while (!probe(sel) && n < wait_limit) begin
			@(negedge clock);
			n++;
		end
		ok = probe(sel);
		if (!ok) begin
			errors++;
			$display("Timeout at time %0t: %s never went high", $time, what);
		end
	endtask

	task automatic hold_cycles(input int n);
		repeat (n) @(negedge clock);
	endtask

	function automatic void add_row(input logic wd, input logic [`LSU_REG_W-1:0] wreg,
		input logic [`LSU_ADDR_W-1:0] addr, input load_op_e ld, input store_op_e st,
		input logic [`LSU_DATA_W-1:0] wdata, input logic [`LSU_DATA_W-1:0] rdata,
		input bus_size_e size, input logic [`LSU_STRB_W-1:0] strb,
		input logic [`LSU_DATA_W-1:0] bus_data, input logic [`LSU_DATA_W-1:0] wb_data);
		row_t r;
		r.req      = '{wd: wd, wreg: wreg, addr: addr, load_op: ld, store_op: st,
			wdata: wdata};
		r.rdata    = rdata;
		r.size     = size;
		r.strb     = strb;
		r.bus_data = bus_data;
		r.wb_data  = wb_data;
		rows.push_back(r);
	endfunction

	// wd, wreg, addr, load op, store op, rs2, read word, size, strb, w data, wb data
	function automatic void load_table();
		// loads outside the regions, offset ignored
		add_row(1'b1, 5'd1, 32'h2000_0001, LD_LB, ST_NONE, 32'h0,
			32'h8a7b_c6f5, SIZE_1, 4'h0, 32'h0, 32'hffff_fff5);
		add_row(1'b1, 5'd2, 32'h2000_0001, LD_LBU, ST_NONE, 32'h0,
			32'h8a7b_c6f5, SIZE_1, 4'h0, 32'h0, 32'h0000_00f5);
		add_row(1'b1, 5'd3, 32'h2000_0002, LD_LH, ST_NONE, 32'h0,
			32'h8a7b_c6f5, SIZE_2, 4'h0, 32'h0, 32'hffff_c6f5);
		add_row(1'b1, 5'd4, 32'h2000_0002, LD_LHU, ST_NONE, 32'h0,
			32'h8a7b_c6f5, SIZE_2, 4'h0, 32'h0, 32'h0000_c6f5);
		add_row(1'b1, 5'd5, 32'h2000_0000, LD_LW, ST_NONE, 32'h0,
			32'h8a7b_c6f5, SIZE_4, 4'h0, 32'h0, 32'h8a7b_c6f5);
		add_row(1'b1, 5'd6, 32'h1000_1001, LD_LBU, ST_NONE, 32'h0, // just past uart
			32'h0000_a5c3, SIZE_1, 4'h0, 32'h0, 32'h0000_00c3);
		// sdram and psram loads, word shifted down by the offset
		add_row(1'b1, 5'd7, 32'ha000_0011, LD_LB, ST_NONE, 32'h0,
			32'h1234_8056, SIZE_1, 4'h0, 32'h0, 32'hffff_ff80);
		add_row(1'b1, 5'd8, 32'ha000_0013, LD_LBU, ST_NONE, 32'h0,
			32'h9c00_0000, SIZE_1, 4'h0, 32'h0, 32'h0000_009c);
		add_row(1'b1, 5'd9, 32'h8000_0102, LD_LH, ST_NONE, 32'h0,
			32'hfedc_0000, SIZE_2, 4'h0, 32'h0, 32'hffff_fedc);
		add_row(1'b1, 5'd10, 32'h8000_0101, LD_LHU, ST_NONE, 32'h0,
			32'h00a5_5a00, SIZE_2, 4'h0, 32'h0, 32'h0000_a55a);
		add_row(1'b1, 5'd11, 32'h8000_0103, LD_LW, ST_NONE, 32'h0,
			32'h7700_0000, SIZE_4, 4'h0, 32'h0, 32'h0000_0077);
		// stores outside, lanes stay put
		add_row(1'b0, 5'd0, 32'h2000_0003, LD_NONE, ST_SB, 32'h1122_3344,
			32'h0, SIZE_1, 4'b0001, 32'h1122_3344, 32'h2000_0003);
		add_row(1'b0, 5'd0, 32'h2000_0002, LD_NONE, ST_SH, 32'h1122_3344,
			32'h0, SIZE_2, 4'b0011, 32'h1122_3344, 32'h2000_0002);
		add_row(1'b0, 5'd0, 32'h2000_0000, LD_NONE, ST_SW, 32'h1122_3344,
			32'h0, SIZE_4, 4'b1111, 32'h1122_3344, 32'h2000_0000);
		// stores in sram, uart, flash, sdram, psram
		add_row(1'b0, 5'd0, 32'h0f00_0002, LD_NONE, ST_SB, 32'h1122_3344,
			32'h0, SIZE_1, 4'b0100, 32'h3344_0000, 32'h0f00_0002);
		add_row(1'b0, 5'd0, 32'h1000_0001, LD_NONE, ST_SH, 32'h1122_3344,
			32'h0, SIZE_2, 4'b0110, 32'h2233_4400, 32'h1000_0001);
		add_row(1'b0, 5'd0, 32'h3000_0003, LD_NONE, ST_SW, 32'h1122_3344,
			32'h0, SIZE_4, 4'b1000, 32'h4400_0000, 32'h3000_0003);
		add_row(1'b0, 5'd0, 32'ha000_0003, LD_NONE, ST_SH, 32'h1122_3344,
			32'h0, SIZE_2, 4'b1000, 32'h4400_0000, 32'ha000_0003);
		add_row(1'b0, 5'd0, 32'h8000_0001, LD_NONE, ST_SB, 32'h1122_3344,
			32'h0, SIZE_1, 4'b0010, 32'h2233_4400, 32'h8000_0001);
		// alu results pass straight through
		add_row(1'b1, 5'd12, 32'h1234_5678, LD_NONE, ST_NONE, 32'h5555_aaaa,
			32'h0, SIZE_4, 4'h0, 32'h0, 32'h1234_5678);
		add_row(1'b0, 5'd0, 32'hcafe_0004, LD_NONE, ST_NONE, 32'h0,
			32'h0, SIZE_4, 4'h0, 32'h0, 32'hcafe_0004);
		add_row(1'b1, 5'd31, 32'ha000_0002, LD_NONE, ST_NONE, 32'h0,
			32'h0, SIZE_4, 4'h0, 32'h0, 32'ha000_0002);
	endfunction

	task automatic run_row(input int idx);
		row_t    r;
		lsu_wb_t held;
		logic    ok;
		logic    is_load;
		logic    is_store;
		int      delay;
		r        = rows[idx];
		is_load  = (r.req.load_op != LD_NONE);
		is_store = !is_load && (r.req.store_op != ST_NONE);
		check(64'(lsu_ready_o), 64'(1'b1), "ready before request");
		req_i       = r.req;
		exu_valid_i = 1'b1; // taken on the next rising edge
		@(negedge clock);
		exu_valid_i = 1'b0;
		req_i       = '0;
		req_i.addr  = $urandom; // unit must work from its latched copy
		if (is_load) begin
			wait_for(p_ar, "ar_valid_o", ok);
			if (!ok) return;
			check(64'(ar_o.addr), 64'(r.req.addr), "read address");
			check(64'(ar_o.size), 64'(r.size), "read size");
			check(64'(aw_valid_o), 64'(1'b0), "write address on a load");
			hold_cycles($urandom_range(3, 0)); // slave stalls the address
			ar_ready_i = 1'b1;
			@(negedge clock);
			ar_ready_i = 1'b0;
			wait_for(p_r, "r_ready_o", ok);
			if (!ok) return;
			hold_cycles($urandom_range(3, 0));
			r_data_i  = r.rdata;
			r_valid_i = 1'b1;
			@(negedge clock);
			r_valid_i = 1'b0;
			r_data_i  = $urandom; // result must come from the captured beat
		end else if (is_store) begin
			wait_for(p_aw, "aw_valid_o and w_valid_o", ok);
			if (!ok) return;
			check(64'(aw_o.addr), 64'(r.req.addr), "write address");
			check(64'(aw_o.size), 64'(r.size), "write size");
			check(64'(w_o.strb), 64'(r.strb), "write strobe");
			check(64'(w_o.data), 64'(r.bus_data), "write data");
			check(64'(ar_valid_o), 64'(1'b0), "read address on a store");
			hold_cycles($urandom_range(3, 0));
			aw_ready_i = 1'b1; // address and data taken together
			w_ready_i  = 1'b1;
			@(negedge clock);
			aw_ready_i = 1'b0;
			w_ready_i  = 1'b0;
			wait_for(p_b, "b_ready_o", ok);
			if (!ok) return;
			hold_cycles($urandom_range(3, 0));
			b_valid_i = 1'b1;
			@(negedge clock);
			b_valid_i = 1'b0;
		end else begin
			// first falling edge after acceptance, still in ADDR
			check(64'(lsu_valid_o), 64'(1'b0), "valid one cycle after accept");
			check(64'({ar_valid_o, aw_valid_o, w_valid_o}), 64'(3'b000), "bus valid on alu op");
			@(negedge clock);
			check(64'(lsu_valid_o), 64'(1'b1), "valid two cycles after accept");
			check(64'({ar_valid_o, aw_valid_o, w_valid_o}), 64'(3'b000), "bus valid on alu op");
		end
		wait_for(p_wb, "lsu_valid_o", ok);
		if (!ok) return;
		check(64'(wb_o.wd), 64'(r.req.wd), "writeback enable");
		check(64'(wb_o.wreg), 64'(r.req.wreg), "writeback register");
		check(64'(wb_o.wdata), 64'(r.wb_data), "writeback data");
		held  = wb_o;
		delay = $urandom_range(3, 0); // writeback stage busy
		repeat (delay) begin
			@(negedge clock);
			check(64'(wb_o), 64'(held), "writeback held");
			check(64'({lsu_valid_o, lsu_ready_o}), 64'(2'b10), "strobes while held");
		end
		wbu_ready_i = 1'b1;
		@(negedge clock);
		wbu_ready_i = 1'b0;
		check(64'({lsu_valid_o, lsu_ready_o}), 64'(2'b01), "idle after writeback");
	endtask

	initial begin
		void'($urandom(51931));
		errors      = 0;
		checks      = 0;
		rstn        = 1'b0;
		exu_valid_i = 1'b0;
		req_i       = '0;
		wbu_ready_i = 1'b0;
		ar_ready_i  = 1'b0;
		aw_ready_i  = 1'b0;
		w_ready_i   = 1'b0;
		r_data_i    = '0;
		r_valid_i   = 1'b0;
		b_valid_i   = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
		// idle state straight out of reset
		check(64'(lsu_ready_o), 64'(1'b1), "ready after reset");
		check(64'({ar_valid_o, aw_valid_o, w_valid_o, r_ready_o, b_ready_o, lsu_valid_o}),
			64'(6'b0), "strobes after reset");
		load_table();
		for (int i = 0; i < rows.size(); i++) begin
			run_row(i);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== lsu.f ====
+incdir+verilog
verilog/lsu_op_pkg.sv
verilog/lsu_bus_pkg.sv
verilog/lsu_ctrl.sv
verilog/lsu_region_decode.sv
verilog/lsu_store_lane.sv
verilog/lsu_load_extract.sv
verilog/lsu_top.sv
testbench/lsu_sva.sv
testbench/tb_lsu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the lsu testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	-f lsu.f --top-module tb_lsu -Mdir obj_dir; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_lsu)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
	exit 0
else
	exit 1
fi
